//--- core_monitor.sv
`timescale 1ns/100ps
`default_nettype none
`include "pdes_cfg.svh"

module core_monitor (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        load_vld,
   input  wire pdes_pkg::core_id_t    load_core,
   input  wire pdes_pkg::lp_id_t      load_lp,
   input  wire pdes_pkg::sim_time_t   load_time,
   input  wire                        done_vld,
   input  wire pdes_pkg::core_id_t    done_core,
   input  wire pdes_pkg::lp_id_t      done_lp,
   input  wire pdes_pkg::hist_t       done_hist,
   input  wire pdes_pkg::core_mask_t  busy,
   output pdes_pkg::core_mask_t       stall,
   output pdes_pkg::hist_t            core_hist [`PDES_NUM_CORE],
   output pdes_pkg::sim_time_t        min_time,
   output logic                       min_time_vld
);

   localparam int n_core     = `PDES_NUM_CORE;
   localparam int tree_depth = $clog2(n_core);
   localparam int scan_wid   = $clog2(`PDES_SCAN_PERIOD);

   // LP and timestamp held by each core
   pdes_pkg::lp_id_t    core_lp   [n_core];
   pdes_pkg::sim_time_t core_time [n_core];
   // last completion count reported per LP
   pdes_pkg::hist_t     lp_hist   [`PDES_NUM_LP];

   // first pipeline stage, registered load and done
   logic                 ld_vld_r;
   logic                 dn_vld_r;
   pdes_pkg::core_id_t   ld_core_r;
   pdes_pkg::core_id_t   dn_core_r;
   pdes_pkg::lp_id_t     dn_lp_r;
   pdes_pkg::core_mask_t ld_match;
   pdes_pkg::core_mask_t dn_match;

   // load side history, release flag and core, as deep as the tree
   logic [tree_depth:0]  hp_rel;
   pdes_pkg::core_id_t   hp_core [tree_depth+1];

   // heap ordered minimum tree, node 1 is the root
   // leaves sit at n_core .. 2*n_core-1
   logic                 node_vld  [1:2*n_core-1];
   pdes_pkg::sim_time_t  node_time [1:2*n_core-1];
   pdes_pkg::core_id_t   node_idx  [1:2*n_core-1];
   logic                 pick_l    [1:n_core-1];

   pdes_pkg::core_mask_t set_mask;
   pdes_pkg::core_mask_t clr_mask;

   // minimum time scan
   logic [scan_wid-1:0]  scan_cnt;
   pdes_pkg::core_id_t   scan_core;
   pdes_pkg::sim_time_t  run_min;
   pdes_pkg::sim_time_t  scan_min;
   logic                 scan_end;

   // load: any other active core on the same LP blocks the release
   // done: every stalled core on the finished LP competes in the tree
   always_comb begin
      for (int i = 0; i < n_core; i++) begin
         ld_match[i] = busy[i] && (core_lp[i] == core_lp[ld_core_r])
                       && (ld_core_r != pdes_pkg::core_id_t'(i));
         dn_match[i] = busy[i] && stall[i] && (core_lp[i] == dn_lp_r)
                       && (dn_core_r != pdes_pkg::core_id_t'(i));
      end
   end

   // left child wins ties and whenever the right one is empty
   always_comb begin
      for (int k = 1; k < n_core; k++) begin
         pick_l[k] = node_vld[2*k]
                     && (!node_vld[2*k+1] || (node_time[2*k] <= node_time[2*k+1]));
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ld_vld_r <= 1'b0;
         dn_vld_r <= 1'b0;
         hp_rel   <= '0;
         stall    <= '0;
         for (int n = 1; n < 2 * n_core; n++) begin
            node_vld[n] <= 1'b0;
         end
      end else begin
         ld_vld_r <= load_vld;
         dn_vld_r <= done_vld;
         hp_rel   <= {hp_rel[tree_depth-1:0], ld_vld_r && (ld_match == '0)};
         for (int i = 0; i < n_core; i++) begin
            node_vld[n_core+i] <= dn_vld_r && dn_match[i];
         end
         for (int k = 1; k < n_core; k++) begin
            node_vld[k] <= node_vld[2*k] || node_vld[2*k+1];
         end
         stall <= (stall & ~clr_mask) | set_mask;
      end
   end

   // table, stage payload and tree data
   always_ff @(posedge clk) begin
      if (load_vld) begin
         core_lp[load_core]   <= load_lp;
         core_time[load_core] <= load_time;
      end
      ld_core_r  <= load_core;
      dn_core_r  <= done_core;
      dn_lp_r    <= done_lp;
      hp_core[0] <= ld_core_r;
      for (int s = 1; s <= tree_depth; s++) begin
         hp_core[s] <= hp_core[s-1];
      end
      for (int i = 0; i < n_core; i++) begin
         node_time[n_core+i] <= core_time[i];
         node_idx[n_core+i]  <= pdes_pkg::core_id_t'(i);
      end
      for (int k = 1; k < n_core; k++) begin
         node_time[k] <= pick_l[k] ? node_time[2*k] : node_time[2*k+1];
         node_idx[k]  <= pick_l[k] ? node_idx[2*k]  : node_idx[2*k+1];
      end
   end

   // newly loaded core stalls at once
   // releases come out of the last stage of either path
   always_comb begin
      set_mask = load_vld ? (pdes_pkg::core_mask_t'(1) << load_core) : '0;
      clr_mask = '0;
      if (hp_rel[tree_depth]) begin
         clr_mask[hp_core[tree_depth]] = 1'b1;
      end
      if (node_vld[1]) begin
         clr_mask[node_idx[1]] = 1'b1;
      end
   end

   // history table, copied to a core in the cycle its stall clears
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int l = 0; l < `PDES_NUM_LP; l++) begin
            lp_hist[l] <= '0;
         end
         for (int i = 0; i < n_core; i++) begin
            core_hist[i] <= '0;
         end
      end else begin
         if (done_vld) begin
            lp_hist[done_lp] <= done_hist;
         end
         if (hp_rel[tree_depth]) begin
            core_hist[hp_core[tree_depth]] <= lp_hist[core_lp[hp_core[tree_depth]]];
         end
         if (node_vld[1]) begin
            core_hist[node_idx[1]] <= lp_hist[core_lp[node_idx[1]]];
         end
      end
   end

   // one core per cycle folded into the running minimum
   assign scan_end = (scan_cnt == scan_wid'(`PDES_SCAN_PERIOD - 1));
   assign scan_min = (busy[scan_core] && (core_time[scan_core] < run_min))
                     ? core_time[scan_core] : run_min;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         scan_cnt     <= '0;
         scan_core    <= '0;
         run_min      <= '1;
         min_time     <= '1;
         min_time_vld <= 1'b0;
      end else begin
         scan_core    <= (scan_core == pdes_pkg::core_id_t'(n_core - 1))
                         ? '0 : scan_core + 1'b1;
         min_time_vld <= scan_end;
         if (scan_end) begin
            // all ones stays when nothing was active in the period
            scan_cnt <= '0;
            run_min  <= '1;
            min_time <= scan_min;
         end else begin
            scan_cnt <= scan_cnt + 1'b1;
            run_min  <= scan_min;
         end
      end
   end

endmodule

`default_nettype wire

//--- event_dispatcher.sv
`timescale 1ns/100ps
`default_nettype none
`include "pdes_cfg.svh"

module event_dispatcher (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        event_vld,
   input  wire pdes_pkg::lp_id_t      event_lp,
   input  wire pdes_pkg::sim_time_t   event_time,
   output logic                       event_ready,
   input  wire pdes_pkg::core_mask_t  busy,
   output logic                       load_vld,
   output pdes_pkg::core_id_t         load_core,
   output pdes_pkg::lp_id_t           load_lp,
   output pdes_pkg::sim_time_t        load_time
);

   // lowest idle core, and whether any core is idle at all
   pdes_pkg::core_id_t free_core;
   logic               free_any;
   logic               accept;

   // priority encoder
   // scan from the top so the lowest idle index is the last one written
   always_comb begin
      free_core = '0;
      free_any  = 1'b0;
      for (int i = `PDES_NUM_CORE - 1; i >= 0; i--) begin
         if (!busy[i]) begin
            free_core = pdes_pkg::core_id_t'(i);
            free_any  = 1'b1;
         end
      end
   end

   // during the load pulse the target core still reads as idle
   // so ready drops for that one cycle
   assign event_ready = free_any && !load_vld;
   assign accept      = event_vld && event_ready;

   // one cycle load strobe
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         load_vld <= 1'b0;
      end else begin
         load_vld <= accept;
      end
   end

   // event fields and target core, held until the next accept
   always_ff @(posedge clk) begin
      if (accept) begin
         load_core <= free_core;
         load_lp   <= event_lp;
         load_time <= event_time;
      end
   end

endmodule

`default_nettype wire

//--- lp_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "pdes_cfg.svh"

module lp_core #(
   parameter int core_index = 0
) (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        load_vld,
   input  wire pdes_pkg::core_id_t    load_core,
   input  wire pdes_pkg::lp_id_t      load_lp,
   input  wire pdes_pkg::sim_time_t   load_time,
   input  wire                        stall,
   input  wire pdes_pkg::hist_t       hist_in,
   output logic                       busy,
   output logic                       ret_req,
   input  wire                        ret_gnt,
   output pdes_pkg::lp_id_t           ret_lp,
   output pdes_pkg::sim_time_t        ret_time,
   output pdes_pkg::hist_t            ret_hist
);

   // wide enough to hold PROC_CYCLES-1
   localparam int cnt_wid = $clog2(`PDES_PROC_CYCLES) + 1;

   pdes_pkg::core_state_t state;
   logic [cnt_wid-1:0]    proc_cnt;
   pdes_pkg::sim_time_t   ev_time;
   logic                  load_hit;
   logic                  run_last;

   // the shared load fields reach every core, only the addressed one takes them
   assign load_hit = load_vld && (load_core == pdes_pkg::core_id_t'(core_index));
   assign run_last = (state == pdes_pkg::run) && (proc_cnt == '0);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state    <= pdes_pkg::idle;
         proc_cnt <= '0;
      end else begin
         case (state)
            pdes_pkg::idle: begin
               if (load_hit) begin
                  state <= pdes_pkg::settle;
               end
            end
            // stall bit from the monitor shows up during this cycle
            pdes_pkg::settle: begin
               state <= pdes_pkg::stalled;
            end
            pdes_pkg::stalled: begin
               if (!stall) begin
                  state    <= pdes_pkg::run;
                  proc_cnt <= cnt_wid'(`PDES_PROC_CYCLES - 1);
               end
            end
            pdes_pkg::run: begin
               if (proc_cnt == '0) begin
                  state <= pdes_pkg::ret;
               end else begin
                  proc_cnt <= proc_cnt - 1'b1;
               end
            end
            // request stays up until the arbiter picks this core
            pdes_pkg::ret: begin
               if (ret_gnt) begin
                  state <= pdes_pkg::idle;
               end
            end
            default: begin
               state <= pdes_pkg::idle;
            end
         endcase
      end
   end

   // event payload, taken at load
   // result fields set on the last run cycle
   always_ff @(posedge clk) begin
      if (load_hit && (state == pdes_pkg::idle)) begin
         ret_lp  <= load_lp;
         ev_time <= load_time;
      end
      if (run_last) begin
         ret_time <= ev_time + pdes_pkg::sim_time_t'(`PDES_LOOKAHEAD);
         // hist_in was written by the monitor when this core was released
         ret_hist <= hist_in + 1'b1;
      end
   end

   assign busy    = (state != pdes_pkg::idle);
   assign ret_req = (state == pdes_pkg::ret);

endmodule

`default_nettype wire

//--- pdes_assert.sv
`timescale 1ns/100ps
`default_nettype none
`include "pdes_cfg.svh"

module core_monitor_assert (
   input wire                        clk,
   input wire                        reset,
   input wire pdes_pkg::core_mask_t  busy,
   input wire pdes_pkg::core_mask_t  stall,
   input wire pdes_pkg::lp_id_t      core_lp [`PDES_NUM_CORE],
   input wire                        min_time_vld
);

   localparam int gap_cyc = `PDES_SCAN_PERIOD - 1;

   // cores holding an event and free to process it
   pdes_pkg::core_mask_t act;
   assign act = busy & ~stall;

   // at most one running core per LP
   for (genvar i = 0; i < `PDES_NUM_CORE; i++) begin : g_a
      for (genvar j = i + 1; j < `PDES_NUM_CORE; j++) begin : g_b
         lp_excl: assert property (@(posedge clk) disable iff (reset)
            !(act[i] && act[j] && (core_lp[i] == core_lp[j])))
            else $error("cores %0d and %0d process the same LP at once", i, j);
      end
   end

   // nothing stalled when reset lets go
   stall_rst: assert property (@(posedge clk) $fell(reset) |-> (stall == '0))
      else $error("stall bits set as reset ends");

   // scan pulse spacing is fixed
   scan_period: assert property (@(posedge clk) disable iff (reset)
      min_time_vld |=> (!min_time_vld) [*gap_cyc] ##1 min_time_vld)
      else $error("min_time_vld spacing differs from the scan period");

endmodule

bind core_monitor core_monitor_assert monitor_assert_inst (
   .clk          (clk),
   .reset        (reset),
   .busy         (busy),
   .stall        (stall),
   .core_lp      (core_lp),
   .min_time_vld (min_time_vld)
);

`default_nettype wire

//--- pdes_cfg.svh
`ifndef PDES_CFG_SVH
`define PDES_CFG_SVH

// processing cores, a power of two so the release tree stays balanced
`define PDES_NUM_CORE 4
// logical processes known to the engine
`define PDES_NUM_LP 8

// timestamp width
`define PDES_TIME_WID 16
// per LP completion count, wraps
`define PDES_HIST_WID 4

// time advance applied by one processed event
`define PDES_LOOKAHEAD 5
// cycles a core spends in run
`define PDES_PROC_CYCLES 4
// cycles per minimum time scan
`define PDES_SCAN_PERIOD 10

`endif

//--- pdes_pkg.sv
`default_nettype none
`include "pdes_cfg.svh"

package pdes_pkg;

   // index of a processing core
   typedef logic [$clog2(`PDES_NUM_CORE)-1:0] core_id_t;

   // index of a logical process
   typedef logic [$clog2(`PDES_NUM_LP)-1:0] lp_id_t;

   // simulation timestamp carried by an event
   typedef logic [`PDES_TIME_WID-1:0] sim_time_t;

   // completions seen so far for one LP
   typedef logic [`PDES_HIST_WID-1:0] hist_t;

   // one bit per core, for busy, stall, request and grant
   typedef logic [`PDES_NUM_CORE-1:0] core_mask_t;

   // core life cycle
   typedef enum logic [2:0] {
      idle,      // free for a new event
      settle,    // first cycle after load, stall bit arrives here
      stalled,   // waiting for the monitor to release the LP
      run,       // fixed processing delay
      ret        // holding the return request
   } core_state_t;

endpackage

`default_nettype wire

//--- pdes_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "pdes_cfg.svh"

module pdes_tb;

   localparam int n_events = 200;
   localparam int n_core   = `PDES_NUM_CORE;
   localparam int tw       = `PDES_TIME_WID;
   localparam int hw       = `PDES_HIST_WID;
   // per event budget of 40 clock periods
   localparam int tmo_ns   = n_events * 40 * 8;

   logic                      clk;
   logic                      reset;
   logic                      event_vld;
   pdes_pkg::lp_id_t          event_lp;
   pdes_pkg::sim_time_t       event_time;
   wire                       event_ready;
   wire                       done_vld;
   wire pdes_pkg::core_id_t   done_core;
   wire pdes_pkg::lp_id_t     done_lp;
   wire pdes_pkg::sim_time_t  done_time;
   wire pdes_pkg::hist_t      done_hist;
   wire pdes_pkg::core_mask_t stall;
   wire pdes_pkg::core_mask_t busy;
   wire pdes_pkg::sim_time_t  min_time;
   wire                       min_time_vld;

   integer seed;

   // accepted events still in flight, in acceptance order
   pdes_pkg::lp_id_t     pend_lp   [$];
   pdes_pkg::sim_time_t  pend_time [$];
   // completions seen so far per LP
   pdes_pkg::hist_t      lp_done_cnt [`PDES_NUM_LP];

   // core occupancy as the testbench sees it
   pdes_pkg::core_mask_t busy_mdl;
   pdes_pkg::lp_id_t     core_lp_mdl   [n_core];
   pdes_pkg::sim_time_t  core_time_mdl [n_core];
   logic                 load_pend;
   pdes_pkg::core_id_t   load_core_mdl;
   pdes_pkg::lp_id_t     load_lp_mdl;
   pdes_pkg::sim_time_t  load_time_mdl;
   logic                 stall_chk;
   pdes_pkg::core_id_t   stall_core;
   int                   done_cnt;
   logic                 full_seen;

   // timestamps in flight over the current scan period
   logic                 win_any;
   pdes_pkg::sim_time_t  win_min;
   pdes_pkg::sim_time_t  win_max;
   // set once a core stays busy through a full round of the scan
   logic                 win_full;
   // consecutive busy cycles per core inside the period
   int                   busy_run [n_core];
   // rising edges since reset released, paces the scan pulse
   int                   scan_tick;

   pdes_top pdes_top_inst (
      .clk          (clk),
      .reset        (reset),
      .event_vld    (event_vld),
      .event_lp     (event_lp),
      .event_time   (event_time),
      .event_ready  (event_ready),
      .done_vld     (done_vld),
      .done_core    (done_core),
      .done_lp      (done_lp),
      .done_time    (done_time),
      .done_hist    (done_hist),
      .stall        (stall),
      .busy         (busy),
      .min_time     (min_time),
      .min_time_vld (min_time_vld)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic check_time(input string name, input pdes_pkg::sim_time_t exp_v,
                             input pdes_pkg::sim_time_t act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("ERROR %0t %s expected %h actual %h", $time, name, exp_v, act_v));
      end
   endtask

   task automatic check_hist(input string name, input pdes_pkg::hist_t exp_v,
                             input pdes_pkg::hist_t act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("ERROR %0t %s expected %h actual %h", $time, name, exp_v, act_v));
      end
   endtask

   task automatic check_lp(input string name, input pdes_pkg::lp_id_t exp_v,
                           input pdes_pkg::lp_id_t act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("ERROR %0t %s expected %h actual %h", $time, name, exp_v, act_v));
      end
   endtask

   task automatic check_mask(input string name, input pdes_pkg::core_mask_t exp_v,
                             input pdes_pkg::core_mask_t act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("ERROR %0t %s expected %b actual %b", $time, name, exp_v, act_v));
      end
   endtask

   task automatic check_flag(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("ERROR %0t %s expected %b actual %b", $time, name, exp_v, act_v));
      end
   endtask

   // expected result is {history, timestamp} for one finished event
   function automatic logic [hw+tw-1:0] ref_done(input pdes_pkg::sim_time_t ev_time,
                                                 input pdes_pkg::hist_t n_prior);
      pdes_pkg::sim_time_t t;
      pdes_pkg::hist_t     h;
      // processing moves the event forward by the lookahead
      t = ev_time + pdes_pkg::sim_time_t'(`PDES_LOOKAHEAD);
      // count of earlier completions plus this one, wraps at the hist width
      h = n_prior + 1'b1;
      return {h, t};
   endfunction

   // dispatcher picks the lowest numbered free core
   function automatic pdes_pkg::core_id_t lowest_idle(input pdes_pkg::core_mask_t m);
      pdes_pkg::core_id_t c;
      c = '0;
      for (int i = n_core - 1; i >= 0; i--) begin
         if (!m[i]) begin
            c = pdes_pkg::core_id_t'(i);
         end
      end
      return c;
   endfunction

   // stimulus, changes on the falling edge only
   initial begin : drive
      pdes_pkg::sim_time_t t_next;
      int                  gap;
      seed       = 69;
      reset      = 1'b1;
      event_vld  = 1'b0;
      event_lp   = '0;
      event_time = '0;
      t_next     = '0;
      busy_mdl   = '0;
      load_pend  = 1'b0;
      stall_chk  = 1'b0;
      done_cnt   = 0;
      full_seen  = 1'b0;
      win_any    = 1'b0;
      win_full   = 1'b0;
      win_min    = '1;
      win_max    = '0;
      scan_tick  = 0;
      for (int l = 0; l < `PDES_NUM_LP; l++) begin
         lp_done_cnt[l] = '0;
      end
      for (int k = 0; k < n_core; k++) begin
         busy_run[k] = 0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < n_events; i++) begin
         // back to back burst in the middle of the run
         gap = (i >= 100 && i < 160) ? 0 : {$random(seed)} % 6;
         repeat (gap) @(negedge clk);
         while (!event_ready) begin
            @(negedge clk);
         end
         // timestamps strictly rise
         t_next     = t_next + pdes_pkg::sim_time_t'(1 + {$random(seed)} % 8);
         event_vld  = 1'b1;
         event_lp   = pdes_pkg::lp_id_t'({$random(seed)} % `PDES_NUM_LP);
         event_time = t_next;
         @(negedge clk);
         event_vld = 1'b0;
      end
      wait (done_cnt == n_events);
      @(negedge clk);
      if (!full_seen) begin
         fail_run("the burst never kept all cores busy at the same time");
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

   // model update and compare, on sampled rising edges
   always @(posedge clk) begin : compare
      int                   idx;
      logic [hw+tw-1:0]     exp_res;
      pdes_pkg::core_mask_t bit_m;
      if (!reset) begin
         // a completion frees its core, one cycle after the grant
         if (done_vld) begin
            check_lp("done_lp", core_lp_mdl[done_core], done_lp);
            idx = -1;
            for (int k = 0; k < pend_lp.size(); k++) begin
               if (idx < 0 && pend_lp[k] == done_lp) begin
                  idx = k;
               end
            end
            if (idx < 0) begin
               fail_run("a completion arrived for an LP with no event in flight");
            end
            // oldest pending event of the LP must be the one that finished
            exp_res = ref_done(pend_time[idx], lp_done_cnt[done_lp]);
            check_time("done_time", exp_res[tw-1:0], done_time);
            check_hist("done_hist", exp_res[hw+tw-1:tw], done_hist);
            lp_done_cnt[done_lp] = lp_done_cnt[done_lp] + 1'b1;
            pend_lp.delete(idx);
            pend_time.delete(idx);
            busy_mdl[done_core] = 1'b0;
            done_cnt++;
         end
         // loaded core shows its stall bit one cycle after the load
         if (stall_chk) begin
            bit_m = pdes_pkg::core_mask_t'(1) << stall_core;
            check_mask("stall", bit_m, stall & bit_m);
            stall_chk = 1'b0;
         end
         check_mask("busy", busy_mdl, busy);
         check_flag("event_ready", !load_pend && (busy_mdl != '1), event_ready);
         if (busy_mdl == '1) begin
            full_seen = 1'b1;
         end
         // scan pulse every period, the first one a full period after reset
         check_flag("min_time_vld",
                    (scan_tick != 0) && (scan_tick % `PDES_SCAN_PERIOD == 0), min_time_vld);
         scan_tick++;
         // scan result lies among the timestamps seen over the period
         // all ones passes only while no core stayed busy through a scan round
         if (min_time_vld) begin
            if (!win_any) begin
               check_time("min_time", '1, min_time);
            end else if (min_time < win_min || (min_time > win_max
                         && (min_time != '1 || win_full))) begin
               fail_run($sformatf("ERROR %0t min_time expected %h..%h actual %h",
                                  $time, win_min, win_max, min_time));
            end
            win_any  = 1'b0;
            win_full = 1'b0;
            win_min  = '1;
            win_max  = '0;
            for (int k = 0; k < n_core; k++) begin
               busy_run[k] = 0;
            end
         end
         for (int k = 0; k < n_core; k++) begin
            if (busy_mdl[k]) begin
               win_any = 1'b1;
               busy_run[k]++;
               if (busy_run[k] >= n_core) begin
                  win_full = 1'b1;
               end
               if (core_time_mdl[k] < win_min) begin
                  win_min = core_time_mdl[k];
               end
               if (core_time_mdl[k] > win_max) begin
                  win_max = core_time_mdl[k];
               end
            end else begin
               busy_run[k] = 0;
            end
         end
         // load pulse ends here, core turns busy
         if (load_pend) begin
            busy_mdl[load_core_mdl]      = 1'b1;
            core_lp_mdl[load_core_mdl]   = load_lp_mdl;
            core_time_mdl[load_core_mdl] = load_time_mdl;
            stall_chk  = 1'b1;
            stall_core = load_core_mdl;
            load_pend  = 1'b0;
         end
         if (event_vld && event_ready) begin
            pend_lp.push_back(event_lp);
            pend_time.push_back(event_time);
            load_pend     = 1'b1;
            load_core_mdl = lowest_idle(busy_mdl);
            load_lp_mdl   = event_lp;
            load_time_mdl = event_time;
         end
      end
   end

   initial begin : watchdog
      #(tmo_ns);
      fail_run("timeout, not every event completed within the time budget");
   end

endmodule

`default_nettype wire

//--- pdes_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "pdes_cfg.svh"

module pdes_top (
   input  wire                        clk,
   input  wire                        reset,
   input  wire                        event_vld,
   input  wire pdes_pkg::lp_id_t      event_lp,
   input  wire pdes_pkg::sim_time_t   event_time,
   output wire                        event_ready,
   output wire                        done_vld,
   output wire pdes_pkg::core_id_t    done_core,
   output wire pdes_pkg::lp_id_t      done_lp,
   output wire pdes_pkg::sim_time_t   done_time,
   output wire pdes_pkg::hist_t       done_hist,
   output wire pdes_pkg::core_mask_t  stall,
   output wire pdes_pkg::core_mask_t  busy,
   output wire pdes_pkg::sim_time_t   min_time,
   output wire                        min_time_vld
);

   // dispatcher load strobe, shared by all cores and the monitor
   wire                       load_vld;
   wire pdes_pkg::core_id_t   load_core;
   wire pdes_pkg::lp_id_t     load_lp;
   wire pdes_pkg::sim_time_t  load_time;

   // return path, one request and grant per core
   wire pdes_pkg::core_mask_t ret_req;
   wire pdes_pkg::core_mask_t ret_gnt;
   wire pdes_pkg::lp_id_t     ret_lp    [`PDES_NUM_CORE];
   wire pdes_pkg::sim_time_t  ret_time  [`PDES_NUM_CORE];
   wire pdes_pkg::hist_t      ret_hist  [`PDES_NUM_CORE];
   wire pdes_pkg::hist_t      core_hist [`PDES_NUM_CORE];

   event_dispatcher dispatcher_inst (
      .clk         (clk),
      .reset       (reset),
      .event_vld   (event_vld),
      .event_lp    (event_lp),
      .event_time  (event_time),
      .event_ready (event_ready),
      .busy        (busy),
      .load_vld    (load_vld),
      .load_core   (load_core),
      .load_lp     (load_lp),
      .load_time   (load_time)
   );

   for (genvar c = 0; c < `PDES_NUM_CORE; c++) begin : g_core
      lp_core #(
         .core_index (c)
      ) core_inst (
         .clk       (clk),
         .reset     (reset),
         .load_vld  (load_vld),
         .load_core (load_core),
         .load_lp   (load_lp),
         .load_time (load_time),
         .stall     (stall[c]),
         .hist_in   (core_hist[c]),
         .busy      (busy[c]),
         .ret_req   (ret_req[c]),
         .ret_gnt   (ret_gnt[c]),
         .ret_lp    (ret_lp[c]),
         .ret_time  (ret_time[c]),
         .ret_hist  (ret_hist[c])
      );
   end

   return_arbiter arbiter_inst (
      .clk       (clk),
      .reset     (reset),
      .ret_req   (ret_req),
      .ret_lp    (ret_lp),
      .ret_time  (ret_time),
      .ret_hist  (ret_hist),
      .ret_gnt   (ret_gnt),
      .done_vld  (done_vld),
      .done_core (done_core),
      .done_lp   (done_lp),
      .done_time (done_time),
      .done_hist (done_hist)
   );

   // monitor sees the load strobe as send and the return bus as receive
   core_monitor monitor_inst (
      .clk          (clk),
      .reset        (reset),
      .load_vld     (load_vld),
      .load_core    (load_core),
      .load_lp      (load_lp),
      .load_time    (load_time),
      .done_vld     (done_vld),
      .done_core    (done_core),
      .done_lp      (done_lp),
      .done_hist    (done_hist),
      .busy         (busy),
      .stall        (stall),
      .core_hist    (core_hist),
      .min_time     (min_time),
      .min_time_vld (min_time_vld)
   );

endmodule

`default_nettype wire

//--- return_arbiter.sv
`timescale 1ns/100ps
`default_nettype none
`include "pdes_cfg.svh"

module return_arbiter (
   input  wire                        clk,
   input  wire                        reset,
   input  wire pdes_pkg::core_mask_t  ret_req,
   input  wire pdes_pkg::lp_id_t      ret_lp   [`PDES_NUM_CORE],
   input  wire pdes_pkg::sim_time_t   ret_time [`PDES_NUM_CORE],
   input  wire pdes_pkg::hist_t       ret_hist [`PDES_NUM_CORE],
   output pdes_pkg::core_mask_t       ret_gnt,
   output logic                       done_vld,
   output pdes_pkg::core_id_t         done_core,
   output pdes_pkg::lp_id_t           done_lp,
   output pdes_pkg::sim_time_t        done_time,
   output pdes_pkg::hist_t            done_hist
);

   localparam int n_core = `PDES_NUM_CORE;

   // core holding the highest priority this cycle
   pdes_pkg::core_id_t ptr;
   pdes_pkg::core_id_t win;
   logic               win_any;

   // walk from the pointer, the nearest requester wins
   // loop runs backwards so the closest candidate is written last
   always_comb begin
      int cand;
      win     = ptr;
      win_any = 1'b0;
      for (int off = n_core - 1; off >= 0; off--) begin
         cand = (int'(ptr) + off) % n_core;
         if (ret_req[cand]) begin
            win     = pdes_pkg::core_id_t'(cand);
            win_any = 1'b1;
         end
      end
   end

   // grant is combinational, the core drops its request at this edge
   assign ret_gnt = win_any ? (pdes_pkg::core_mask_t'(1) << win) : '0;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ptr      <= '0;
         done_vld <= 1'b0;
      end else begin
         done_vld <= win_any;
         // winner drops to lowest priority
         if (win_any) begin
            ptr <= (win == pdes_pkg::core_id_t'(n_core - 1)) ? '0 : win + 1'b1;
         end
      end
   end

   // registered shared return bus
   always_ff @(posedge clk) begin
      if (win_any) begin
         done_core <= win;
         done_lp   <= ret_lp[win];
         done_time <= ret_time[win];
         done_hist <= ret_hist[win];
      end
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
pdes_pkg.sv
event_dispatcher.sv
lp_core.sv
return_arbiter.sv
core_monitor.sv
pdes_top.sv
pdes_assert.sv
pdes_tb.sv
